// ==== hw/vic_sprite_pkg.sv ====
`default_nettype none

package vic_sprite_pkg;

    // number of hardware sprites and the width of a sprite index
    localparam int NUM_SPRITES = 8;
    localparam int SPRITE_IDX_W = $clog2(NUM_SPRITES);

    // clk_dot4x ticks per phi cycle, phi low in the first half
    localparam int PHASES_PER_CYCLE = 32;
    localparam int HALF_CYCLE = PHASES_PER_CYCLE / 2;

    // line events of the sprite sequencer, all at the start of phi high
    localparam int DMA_CHK_CYCLE = 1;
    localparam int YEXP_CHK_CYCLE = 2;
    localparam int DISP_CHK_CYCLE = 3;
    localparam int MCBASE_CYCLE = 4;
    // sprite n is fetched in cycle FETCH_CYCLE0 + n
    localparam int FETCH_CYCLE0 = 5;

    typedef struct packed {
        logic [4:0] phase;
        logic       phi;
        logic       dot;
        logic [6:0] cycle_num;
        logic [8:0] xpos;
        logic [7:0] raster;
    } beam_t;

    typedef struct packed {
        logic [8:0] x;
        logic [7:0] y;
        logic       en;
        logic       xe;
        logic       ye;
        logic       mmc;
    } sprite_cfg_t;

    typedef struct packed {
        logic                    valid;
        logic [SPRITE_IDX_W-1:0] idx;
        logic [5:0]              mc;
    } fetch_req_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } fetch_rsp_t;

    typedef struct packed {
        logic                    valid;
        logic [SPRITE_IDX_W-1:0] idx;
        logic [23:0]             row;
    } row_load_t;

    typedef struct packed {
        logic [NUM_SPRITES-1:0] m2m;
        logic [NUM_SPRITES-1:0] m2d;
        logic                   immc;
        logic                   imbc;
    } coll_t;

endpackage

`default_nettype wire

// ==== hw/beam_timer.sv ====
`timescale 1ns/1ns
`default_nettype none

module beam_timer #(
    parameter int LINE_CYCLES = 63,
    parameter int FRAME_LINES = 312
) (
    input  logic                  clk_dot4x,
    input  logic                  rst,
    output vic_sprite_pkg::beam_t beam
);

    logic [4:0] phase_q;
    logic [6:0] cycle_q;
    // full line count, only the low byte is compared against sprite y
    logic [8:0] line_q;
    logic [8:0] xpos_q;
    logic       dot;
    logic       cycle_end;
    logic       line_end;

    // one dot every four clk_dot4x
    assign dot = phase_q[1:0] == 2'd0;
    assign cycle_end = phase_q == 5'(vic_sprite_pkg::PHASES_PER_CYCLE - 1);
    assign line_end = cycle_end && (cycle_q == 7'(LINE_CYCLES - 1));

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            phase_q <= '0;
            cycle_q <= '0;
            line_q <= '0;
            xpos_q <= '0;
        end else begin
            if (cycle_end) begin
                phase_q <= '0;
            end else begin
                phase_q <= phase_q + 5'd1;
            end

            if (line_end) begin
                cycle_q <= '0;
            end else if (cycle_end) begin
                cycle_q <= cycle_q + 7'd1;
            end

            // raster wraps after the last cycle of the last line
            if (line_end) begin
                if (line_q == 9'(FRAME_LINES - 1)) begin
                    line_q <= '0;
                end else begin
                    line_q <= line_q + 9'd1;
                end
            end

            // horizontal position restarts at the first phase of the line
            if (phase_q == 5'd0 && cycle_q == 7'd0) begin
                xpos_q <= '0;
            end else if (dot) begin
                xpos_q <= xpos_q + 9'd1;
            end
        end
    end

    // phi is high in the second half of the cycle
    always_comb begin
        beam.phase = phase_q;
        beam.phi = phase_q[4];
        beam.dot = dot;
        beam.cycle_num = cycle_q;
        beam.xpos = xpos_q;
        beam.raster = line_q[7:0];
    end

endmodule

`default_nettype wire

// ==== hw/sprite_dma_seq.sv ====
`timescale 1ns/1ns
`default_nettype none

module sprite_dma_seq #(
    parameter int LINE_CYCLES = 63
) (
    input  logic                                                       clk_dot4x,
    input  logic                                                       rst,
    input  vic_sprite_pkg::beam_t                                      beam,
    input  vic_sprite_pkg::sprite_cfg_t [vic_sprite_pkg::NUM_SPRITES-1:0] cfg,
    output vic_sprite_pkg::fetch_req_t                                 fetch_req,
    input  vic_sprite_pkg::fetch_rsp_t                                 fetch_rsp,
    output vic_sprite_pkg::row_load_t                                  row_load
);

    localparam int NS = vic_sprite_pkg::NUM_SPRITES;
    localparam int IW = vic_sprite_pkg::SPRITE_IDX_W;
    localparam int FETCH0 = vic_sprite_pkg::FETCH_CYCLE0;
    // fetch window, clipped when the line is too short for all sprites
    localparam int FETCH_END = (FETCH0 + NS < LINE_CYCLES) ? FETCH0 + NS : LINE_CYCLES;

    logic [5:0]    mc [NS];
    logic [5:0]    mcbase [NS];
    logic [NS-1:0] dma;
    logic [NS-1:0] yexp_ff;

    logic [6:0]    slot;
    logic [IW-1:0] slot_idx;
    logic          in_window;
    logic          fetch_phase;
    logic          seq_event;
    logic [1:0]    byte_cnt;
    // first two bytes of the row, high byte on top
    logic [15:0]   row_buf;

    assign slot = beam.cycle_num - 7'(FETCH0);
    assign slot_idx = slot[IW-1:0];
    assign in_window = (beam.cycle_num >= 7'(FETCH0)) && (beam.cycle_num < 7'(FETCH_END));
    assign fetch_phase = (beam.phase == 5'd0) || (beam.phase == 5'd8) ||
                         (beam.phase == 5'(vic_sprite_pkg::HALF_CYCLE));
    assign seq_event = beam.phase == 5'(vic_sprite_pkg::HALF_CYCLE);

    // three byte requests per sprite slot, only while its DMA runs
    always_comb begin
        fetch_req.valid = in_window && fetch_phase && dma[slot_idx];
        fetch_req.idx = slot_idx;
        fetch_req.mc = mc[slot_idx];
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            for (int n = 0; n < NS; n++) begin
                mc[n] <= 6'd63;
                mcbase[n] <= 6'd63;
            end
            dma <= '0;
            yexp_ff <= '1;
        end else begin
            if (seq_event) begin
                for (int n = 0; n < NS; n++) begin
                    if (beam.cycle_num == 7'(vic_sprite_pkg::DMA_CHK_CYCLE)) begin
                        if (!dma[n] && cfg[n].en && cfg[n].y == beam.raster) begin
                            dma[n] <= 1'b1;
                            mcbase[n] <= 6'd0;
                            yexp_ff[n] <= 1'b1;
                        end
                    end
                    if (beam.cycle_num == 7'(vic_sprite_pkg::YEXP_CHK_CYCLE)) begin
                        if (dma[n] && cfg[n].ye) begin
                            yexp_ff[n] <= ~yexp_ff[n];
                        end
                    end
                    if (beam.cycle_num == 7'(vic_sprite_pkg::DISP_CHK_CYCLE)) begin
                        mc[n] <= mcbase[n];
                    end
                    // mcbase only advances on the second line of an expanded row
                    if (beam.cycle_num == 7'(vic_sprite_pkg::MCBASE_CYCLE) && yexp_ff[n]) begin
                        mcbase[n] <= mc[n];
                        if (mc[n] == 6'd63) begin
                            dma[n] <= 1'b0;
                        end
                    end
                end
            end
            // the answer always lands inside the slot of the requesting sprite
            if (fetch_rsp.valid) begin
                mc[slot_idx] <= mc[slot_idx] + 6'd1;
            end
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            byte_cnt <= '0;
            row_load.valid <= 1'b0;
        end else begin
            row_load.valid <= 1'b0;
            if (fetch_req.valid && beam.phase == 5'd0) begin
                byte_cnt <= '0;
            end
            if (fetch_rsp.valid) begin
                row_buf <= {row_buf[7:0], fetch_rsp.data};
                if (byte_cnt == 2'd2) begin
                    byte_cnt <= '0;
                    row_load.valid <= 1'b1;
                    row_load.idx <= slot_idx;
                    row_load.row <= {row_buf, fetch_rsp.data};
                end else begin
                    byte_cnt <= byte_cnt + 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/sprite_shifter.sv ====
`timescale 1ns/1ns
`default_nettype none

module sprite_shifter (
    input  logic                                                       clk_dot4x,
    input  logic                                                       rst,
    input  vic_sprite_pkg::beam_t                                      beam,
    input  vic_sprite_pkg::sprite_cfg_t [vic_sprite_pkg::NUM_SPRITES-1:0] cfg,
    input  vic_sprite_pkg::row_load_t                                  row_load,
    output logic [vic_sprite_pkg::NUM_SPRITES-1:0][1:0]                pixel_code
);

    localparam int NS = vic_sprite_pkg::NUM_SPRITES;
    localparam int IW = vic_sprite_pkg::SPRITE_IDX_W;
    localparam logic [4:0] ROW_BITS = 5'd24;

    logic [23:0]   shreg [NS];
    logic [4:0]    bits_left [NS];
    logic [NS-1:0] armed;
    logic [NS-1:0] xe_ff;
    logic [NS-1:0] mmc_ff;

    // state as seen by this dot, after a possible x match restart
    logic [NS-1:0] x_hit;
    logic [NS-1:0] run_xe;
    logic [NS-1:0] run_mmc;
    logic [4:0]    run_left [NS];
    logic [NS-1:0] active;

    always_comb begin
        for (int n = 0; n < NS; n++) begin
            x_hit[n] = cfg[n].x == beam.xpos;
            run_xe[n] = x_hit[n] ? 1'b0 : xe_ff[n];
            run_mmc[n] = x_hit[n] ? 1'b0 : mmc_ff[n];
            run_left[n] = x_hit[n] ? ROW_BITS : bits_left[n];
            // the last bit of an expanded row still needs its second dot
            active[n] = (armed[n] || x_hit[n]) && (run_left[n] != 5'd0 || run_xe[n]);
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            for (int n = 0; n < NS; n++) begin
                bits_left[n] <= '0;
            end
            armed <= '0;
            xe_ff <= '0;
            mmc_ff <= '0;
            pixel_code <= '0;
        end else begin
            for (int n = 0; n < NS; n++) begin
                if (beam.dot) begin
                    if (!active[n]) begin
                        armed[n] <= 1'b0;
                        xe_ff[n] <= 1'b0;
                        mmc_ff[n] <= 1'b0;
                        bits_left[n] <= '0;
                        pixel_code[n] <= 2'd0;
                    end else begin
                        armed[n] <= 1'b1;
                        xe_ff[n] <= cfg[n].xe & ~run_xe[n];
                        // with x expansion a bit is held for a second dot
                        if (!run_xe[n]) begin
                            bits_left[n] <= run_left[n] - 5'd1;
                            shreg[n] <= {shreg[n][22:0], 1'b0};
                            mmc_ff[n] <= cfg[n].mmc & ~run_mmc[n];
                            if (!run_mmc[n]) begin
                                pixel_code[n] <= cfg[n].mmc ? shreg[n][23:22] :
                                                              {shreg[n][23], 1'b0};
                            end
                        end
                    end
                end
                if (row_load.valid && row_load.idx == IW'(n)) begin
                    shreg[n] <= row_load.row;
                    if (armed[n]) begin
                        bits_left[n] <= ROW_BITS;
                        xe_ff[n] <= 1'b0;
                        mmc_ff[n] <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/sprite_collision.sv ====
`timescale 1ns/1ns
`default_nettype none

module sprite_collision (
    input  logic                                        clk_dot4x,
    input  logic                                        rst,
    input  vic_sprite_pkg::beam_t                       beam,
    input  logic [vic_sprite_pkg::NUM_SPRITES-1:0][1:0] pixel_code,
    input  logic                                        fg_pixel,
    input  logic                                        border,
    input  logic                                        m2m_clr,
    input  logic                                        m2d_clr,
    input  logic                                        immc_clr,
    input  logic                                        imbc_clr,
    output vic_sprite_pkg::coll_t                       coll
);

    localparam int NS = vic_sprite_pkg::NUM_SPRITES;

    logic [NS-1:0] opaque;
    logic          multi;

    // channel 0 is sprite to sprite, channel 1 is sprite to data
    logic [NS-1:0] hit [2];
    logic [NS-1:0] pend [2];
    logic [NS-1:0] vis [2];
    logic [1:0]    clr;
    logic [1:0]    irq_clr;
    logic [1:0]    trig;
    logic [1:0]    irq_pend;
    logic [1:0]    irq;

    always_comb begin
        for (int n = 0; n < NS; n++) begin
            opaque[n] = pixel_code[n] != 2'd0;
        end
        // more than one bit set
        multi = (opaque & (opaque - NS'(1))) != '0;
        hit[0] = multi ? opaque : '0;
        hit[1] = (fg_pixel && !border) ? opaque : '0;
    end

    assign clr = {m2d_clr, m2m_clr};
    assign irq_clr = {imbc_clr, immc_clr};

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            for (int c = 0; c < 2; c++) begin
                pend[c] <= '0;
                vis[c] <= '0;
            end
            trig <= '0;
            irq_pend <= '0;
            irq <= '0;
        end else begin
            for (int c = 0; c < 2; c++) begin
                if (hit[c] != '0) begin
                    pend[c] <= pend[c] | hit[c];
                    // only the first hit after a register clear interrupts
                    if (!trig[c]) begin
                        trig[c] <= 1'b1;
                        irq_pend[c] <= 1'b1;
                    end
                end
                // hits found in phi high wait here for the next low phase
                if (!beam.phi) begin
                    vis[c] <= pend[c];
                    irq[c] <= irq_pend[c];
                end
                if (clr[c]) begin
                    pend[c] <= '0;
                    vis[c] <= '0;
                    trig[c] <= 1'b0;
                end
                if (irq_clr[c]) begin
                    irq_pend[c] <= 1'b0;
                    irq[c] <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        coll.m2m = vis[0];
        coll.m2d = vis[1];
        coll.immc = irq[0];
        coll.imbc = irq[1];
    end

endmodule

`default_nettype wire

// ==== hw/sprite_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module sprite_top #(
    parameter int LINE_CYCLES = 63,
    parameter int FRAME_LINES = 312
) (
    input  logic                                                       clk_dot4x,
    input  logic                                                       rst,
    input  vic_sprite_pkg::sprite_cfg_t [vic_sprite_pkg::NUM_SPRITES-1:0] cfg,
    output vic_sprite_pkg::fetch_req_t                                 fetch_req,
    input  vic_sprite_pkg::fetch_rsp_t                                 fetch_rsp,
    input  logic                                                       fg_pixel,
    input  logic                                                       border,
    input  logic                                                       m2m_clr,
    input  logic                                                       m2d_clr,
    input  logic                                                       immc_clr,
    input  logic                                                       imbc_clr,
    output vic_sprite_pkg::beam_t                                      beam,
    output logic [vic_sprite_pkg::NUM_SPRITES-1:0][1:0]                pixel_code,
    output vic_sprite_pkg::coll_t                                      coll
);

    // completed rows from the sequencer to the shifters
    vic_sprite_pkg::row_load_t row_load;

    beam_timer #(
        .LINE_CYCLES(LINE_CYCLES),
        .FRAME_LINES(FRAME_LINES)
    ) u_beam_timer (
        .clk_dot4x(clk_dot4x),
        .rst(rst),
        .beam(beam)
    );

    sprite_dma_seq #(
        .LINE_CYCLES(LINE_CYCLES)
    ) u_sprite_dma_seq (
        .clk_dot4x(clk_dot4x),
        .rst(rst),
        .beam(beam),
        .cfg(cfg),
        .fetch_req(fetch_req),
        .fetch_rsp(fetch_rsp),
        .row_load(row_load)
    );

    sprite_shifter u_sprite_shifter (
        .clk_dot4x(clk_dot4x),
        .rst(rst),
        .beam(beam),
        .cfg(cfg),
        .row_load(row_load),
        .pixel_code(pixel_code)
    );

    sprite_collision u_sprite_collision (
        .clk_dot4x(clk_dot4x),
        .rst(rst),
        .beam(beam),
        .pixel_code(pixel_code),
        .fg_pixel(fg_pixel),
        .border(border),
        .m2m_clr(m2m_clr),
        .m2d_clr(m2d_clr),
        .immc_clr(immc_clr),
        .imbc_clr(imbc_clr),
        .coll(coll)
    );

endmodule

`default_nettype wire

// ==== verification/sprite_model.svh ====
// reference state updated once per clock from the inputs the DUT samples
logic [4:0]  m_phase;
logic [6:0]  m_cycle;
logic [8:0]  m_line;
logic [8:0]  m_xpos;
logic [5:0]  m_mc [8];
logic [5:0]  m_mcbase [8];
logic [7:0]  m_dma;
logic [7:0]  m_yexp;
logic [1:0]  m_cnt;
logic [15:0] m_buf;
logic        m_ld;
logic [2:0]  m_ld_idx;
logic [23:0] m_ld_row;
logic [23:0] m_sh [8];
logic [4:0]  m_left [8];
logic [7:0]  m_armed;
logic [7:0]  m_xe_half;
logic [7:0]  m_mc_half;
logic [1:0]  m_code [8];
logic [7:0]  m_pend [2];
logic [7:0]  m_vis [2];
logic [1:0]  m_trig;
logic [1:0]  m_irq_pend;
logic [1:0]  m_irq;

function automatic logic expect_fetch_valid();
    logic [6:0] slot;
    slot = m_cycle - 7'd5;
    return (m_cycle >= 7'd5) && (m_cycle < 7'd13) && m_dma[slot[2:0]] &&
           (m_phase == 5'd0 || m_phase == 5'd8 || m_phase == 5'd16);
endfunction

task automatic reset_reference();
    m_phase = '0;
    m_cycle = '0;
    m_line = '0;
    m_xpos = '0;
    for (int n = 0; n < 8; n++) begin
        m_mc[n] = 6'd63;
        m_mcbase[n] = 6'd63;
        m_left[n] = '0;
        m_code[n] = '0;
    end
    m_dma = '0;
    m_yexp = '1;
    m_cnt = '0;
    m_ld = 1'b0;
    m_armed = '0;
    m_xe_half = '0;
    m_mc_half = '0;
    for (int c = 0; c < 2; c++) begin
        m_pend[c] = '0;
        m_vis[c] = '0;
    end
    m_trig = '0;
    m_irq_pend = '0;
    m_irq = '0;
endtask

// collision rules use the pixel codes before the shifter moves them on
task automatic apply_collision_rules();
    logic [7:0] opq;
    logic [7:0] hit [2];
    int         cnt;
    logic [1:0] clr;
    logic [1:0] iclr;
    cnt = 0;
    for (int n = 0; n < 8; n++) begin
        opq[n] = m_code[n] != 2'd0;
        cnt += int'(opq[n]);
    end
    hit[0] = (cnt >= 2) ? opq : 8'd0;
    hit[1] = (fg_pixel && !border) ? opq : 8'd0;
    clr = {m2d_clr, m2m_clr};
    iclr = {imbc_clr, immc_clr};
    for (int c = 0; c < 2; c++) begin
        // visible copy takes the value from before this clock's hits
        if (!m_phase[4]) begin
            m_vis[c] = m_pend[c];
            m_irq[c] = m_irq_pend[c];
        end
        if (hit[c] != 8'd0) begin
            m_pend[c] = m_pend[c] | hit[c];
            if (!m_trig[c]) begin
                m_trig[c] = 1'b1;
                m_irq_pend[c] = 1'b1;
            end
        end
        if (clr[c]) begin
            m_pend[c] = '0;
            m_vis[c] = '0;
            m_trig[c] = 1'b0;
        end
        if (iclr[c]) begin
            m_irq_pend[c] = 1'b0;
            m_irq[c] = 1'b0;
        end
    end
endtask

task automatic shift_sprites();
    logic hit;
    logic was_armed;
    logic xeh;
    logic mch;
    logic [4:0] left;
    for (int n = 0; n < 8; n++) begin
        was_armed = m_armed[n];
        if (m_phase[1:0] == 2'd0) begin
            hit = cfg[n].x == m_xpos;
            xeh = hit ? 1'b0 : m_xe_half[n];
            mch = hit ? 1'b0 : m_mc_half[n];
            left = hit ? 5'd24 : m_left[n];
            if (!((was_armed || hit) && (left != 5'd0 || xeh))) begin
                m_armed[n] = 1'b0;
                m_xe_half[n] = 1'b0;
                m_mc_half[n] = 1'b0;
                m_left[n] = '0;
                m_code[n] = 2'd0;
            end else if (xeh) begin
                // second dot of an x-expanded bit
                m_armed[n] = 1'b1;
                m_xe_half[n] = 1'b0;
            end else begin
                m_armed[n] = 1'b1;
                m_xe_half[n] = cfg[n].xe;
                m_left[n] = left - 5'd1;
                if (mch) begin
                    m_mc_half[n] = 1'b0;
                end else begin
                    m_mc_half[n] = cfg[n].mmc;
                    m_code[n] = cfg[n].mmc ? m_sh[n][23:22] : {m_sh[n][23], 1'b0};
                end
                m_sh[n] = m_sh[n] << 1;
            end
        end
        if (m_ld && m_ld_idx == 3'(n)) begin
            m_sh[n] = m_ld_row;
            if (was_armed) begin
                m_left[n] = 5'd24;
                m_xe_half[n] = 1'b0;
                m_mc_half[n] = 1'b0;
            end
        end
    end
endtask

task automatic run_sequencer();
    logic [6:0] slot;
    logic [1:0] old_cnt;
    slot = m_cycle - 7'd5;
    old_cnt = m_cnt;
    if (expect_fetch_valid() && m_phase == 5'd0) begin
        m_cnt = '0;
    end
    m_ld = 1'b0;
    if (fetch_rsp.valid) begin
        if (old_cnt == 2'd2) begin
            m_cnt = '0;
            m_ld = 1'b1;
            m_ld_idx = slot[2:0];
            m_ld_row = {m_buf, fetch_rsp.data};
        end else begin
            m_cnt = old_cnt + 2'd1;
        end
        m_buf = {m_buf[7:0], fetch_rsp.data};
    end
    if (m_phase == 5'd16) begin
        for (int n = 0; n < 8; n++) begin
            if (m_cycle == 7'd1 && !m_dma[n] && cfg[n].en && cfg[n].y == m_line[7:0]) begin
                m_dma[n] = 1'b1;
                m_mcbase[n] = 6'd0;
                m_yexp[n] = 1'b1;
            end
            if (m_cycle == 7'd2 && m_dma[n] && cfg[n].ye) begin
                m_yexp[n] = ~m_yexp[n];
            end
            if (m_cycle == 7'd3) begin
                m_mc[n] = m_mcbase[n];
            end
            if (m_cycle == 7'd4 && m_yexp[n]) begin
                m_mcbase[n] = m_mc[n];
                if (m_mc[n] == 6'd63) begin
                    m_dma[n] = 1'b0;
                end
            end
        end
    end
    if (fetch_rsp.valid) begin
        m_mc[slot[2:0]] = m_mc[slot[2:0]] + 6'd1;
    end
endtask

task automatic advance_beam();
    if (m_phase == 5'd0 && m_cycle == 7'd0) begin
        m_xpos = '0;
    end else if (m_phase[1:0] == 2'd0) begin
        m_xpos = m_xpos + 9'd1;
    end
    if (m_phase == 5'd31) begin
        if (m_cycle == 7'(LINE_CYCLES - 1)) begin
            m_cycle = '0;
            m_line = (m_line == 9'(FRAME_LINES - 1)) ? 9'd0 : m_line + 9'd1;
        end else begin
            m_cycle = m_cycle + 7'd1;
        end
    end
    m_phase = m_phase + 5'd1;
endtask

task automatic step_reference();
    apply_collision_rules();
    shift_sprites();
    run_sequencer();
    advance_beam();
endtask

// ==== verification/tb_sprite.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_sprite;

    localparam int LINE_CYCLES = 40;
    localparam int FRAME_LINES = 16;
    localparam int NUM_FRAMES = 10;
    localparam int FRAME_CLKS = FRAME_LINES * LINE_CYCLES * 32;
    localparam longint LIMIT_NS = longint'(NUM_FRAMES * FRAME_CLKS + 2000) * 8;

    logic clk_dot4x;
    logic rst;
    vic_sprite_pkg::sprite_cfg_t [vic_sprite_pkg::NUM_SPRITES-1:0] cfg;
    vic_sprite_pkg::fetch_req_t fetch_req;
    vic_sprite_pkg::fetch_rsp_t fetch_rsp;
    vic_sprite_pkg::fetch_rsp_t rsp_pipe;
    logic fg_pixel;
    logic border;
    logic m2m_clr;
    logic m2d_clr;
    logic immc_clr;
    logic imbc_clr;
    vic_sprite_pkg::beam_t beam;
    logic [vic_sprite_pkg::NUM_SPRITES-1:0][1:0] pixel_code;
    vic_sprite_pkg::coll_t coll;
    int error_count;

    `include "sprite_model.svh"

    sprite_top #(
        .LINE_CYCLES(LINE_CYCLES),
        .FRAME_LINES(FRAME_LINES)
    ) u_dut (
        .clk_dot4x(clk_dot4x),
        .rst(rst),
        .cfg(cfg),
        .fetch_req(fetch_req),
        .fetch_rsp(fetch_rsp),
        .fg_pixel(fg_pixel),
        .border(border),
        .m2m_clr(m2m_clr),
        .m2d_clr(m2d_clr),
        .immc_clr(immc_clr),
        .imbc_clr(imbc_clr),
        .beam(beam),
        .pixel_code(pixel_code),
        .coll(coll)
    );

    initial begin
        clk_dot4x = 1'b0;
        forever #4 clk_dot4x = ~clk_dot4x;
    end

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    task automatic compare_outputs();
        logic [6:0] slot;
        slot = m_cycle - 7'd5;
        check_val("beam.phase", 32'(beam.phase), 32'(m_phase));
        check_val("beam.phi", 32'(beam.phi), 32'(m_phase[4]));
        check_val("beam.dot", 32'(beam.dot), 32'(m_phase[1:0] == 2'd0));
        check_val("beam.cycle_num", 32'(beam.cycle_num), 32'(m_cycle));
        check_val("beam.xpos", 32'(beam.xpos), 32'(m_xpos));
        check_val("beam.raster", 32'(beam.raster), 32'(m_line[7:0]));
        check_val("fetch_req.valid", 32'(fetch_req.valid), 32'(expect_fetch_valid()));
        if (expect_fetch_valid()) begin
            check_val("fetch_req.idx", 32'(fetch_req.idx), 32'(slot[2:0]));
            check_val("fetch_req.mc", 32'(fetch_req.mc), 32'(m_mc[slot[2:0]]));
        end
        for (int n = 0; n < 8; n++) begin
            check_val($sformatf("pixel_code[%0d]", n), 32'(pixel_code[n]), 32'(m_code[n]));
        end
        check_val("coll.m2m", 32'(coll.m2m), 32'(m_vis[0]));
        check_val("coll.m2d", 32'(coll.m2d), 32'(m_vis[1]));
        check_val("coll.immc", 32'(coll.immc), 32'(m_irq[0]));
        check_val("coll.imbc", 32'(coll.imbc), 32'(m_irq[1]));
    endtask

    // memory contents as a mix of sprite index and data counter
    function automatic logic [7:0] mem_byte(input logic [2:0] idx, input logic [5:0] mc);
        return ({5'd0, idx} * 8'h3b) ^ ({2'd0, mc} * 8'h1d) ^ 8'ha5;
    endfunction

    always @(posedge clk_dot4x) begin
        if (rst) begin
            rsp_pipe <= '0;
            fetch_rsp <= '0;
        end else begin
            rsp_pipe.valid <= fetch_req.valid;
            rsp_pipe.data <= mem_byte(fetch_req.idx, fetch_req.mc);
            fetch_rsp <= rsp_pipe;
        end
    end

    always @(negedge clk_dot4x) begin
        if (rst === 1'b0) begin
            compare_outputs();
            step_reference();
        end else begin
            reset_reference();
        end
    end

    task automatic pick_sprite_layout();
        for (int n = 0; n < 8; n++) begin
            cfg[n].x <= 9'($urandom_range(0, 150));
            cfg[n].y <= 8'($urandom_range(0, FRAME_LINES - 1));
            cfg[n].en <= $urandom_range(0, 3) != 0;
            cfg[n].xe <= 1'($urandom_range(0, 1));
            cfg[n].ye <= 1'($urandom_range(0, 1));
            cfg[n].mmc <= 1'($urandom_range(0, 1));
        end
    endtask

    task automatic drive_pixel_inputs();
        fg_pixel <= 1'($urandom_range(0, 1));
        border <= $urandom_range(0, 3) == 0;
        m2m_clr <= $urandom_range(0, 63) == 0;
        m2d_clr <= $urandom_range(0, 63) == 0;
        immc_clr <= $urandom_range(0, 63) == 0;
        imbc_clr <= $urandom_range(0, 63) == 0;
    endtask

    initial begin
        #(LIMIT_NS);
        $display("watchdog expired before the last frame finished");
        $display("Test FAILED");
        $fatal(1);
    end

    initial begin
        void'($urandom(92));
        error_count = 0;
        rst = 1'b1;
        cfg = '0;
        fetch_rsp = '0;
        rsp_pipe = '0;
        fg_pixel = 1'b0;
        border = 1'b0;
        m2m_clr = 1'b0;
        m2d_clr = 1'b0;
        immc_clr = 1'b0;
        imbc_clr = 1'b0;
        reset_reference();
        repeat (5) @(posedge clk_dot4x);
        rst <= 1'b0;
        pick_sprite_layout();
        repeat (NUM_FRAMES * FRAME_CLKS) begin
            @(posedge clk_dot4x);
            // new sprite layout at the first clock of each frame
            if (beam.raster == 8'd0 && beam.cycle_num == 7'd0 && beam.phase == 5'd0) begin
                pick_sprite_layout();
            end
            drive_pixel_inputs();
        end
        @(posedge clk_dot4x);
        if (error_count == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            $display("Test FAILED");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+verification
hw/vic_sprite_pkg.sv
hw/beam_timer.sv
hw/sprite_dma_seq.sv
hw/sprite_shifter.sv
hw/sprite_collision.sv
hw/sprite_top.sv
verification/tb_sprite.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the sprite testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f list.f --top-module tb_sprite -Mdir obj_dir -o tb_sprite_sim \
    > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_sprite_sim > sim.log 2>&1
grep -q "Test OK" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
